// ==== verilog/mpeg_codes_pkg.sv ====
// MPEG-1 system layer codes
`default_nettype none

package mpeg_codes_pkg;

   // start code prefix bytes, 0x000001
   localparam logic [7:0] PREFIX_ZERO = 8'h00;
   localparam logic [7:0] PREFIX_LAST = 8'h01;

   // code bytes after the prefix
   localparam logic [7:0] END_CODE        = 8'hB9;
   localparam logic [7:0] PACK_START_CODE = 8'hBA;
   localparam logic [7:0] SYS_HEADER_CODE = 8'hBB;
   localparam logic [7:0] FIRST_PES_ID    = 8'hBC;  // lowest stream id
   localparam logic [7:0] PRIVATE_STREAM_2 = 8'hBF; // no header extension

   // PES header bytes
   localparam logic [7:0] STUFFING_BYTE = 8'hFF;
   localparam logic [7:0] TS_NONE_BYTE  = 8'h0F;

   // lead byte prefixes
   localparam logic [3:0] TS_PTS_PREFIX     = 4'b0010;
   localparam logic [3:0] TS_PTS_DTS_PREFIX = 4'b0011;
   localparam logic [1:0] STD_PREFIX        = 2'b01;

endpackage

`default_nettype wire

// ==== verilog/mpeg_fields_pkg.sv ====
// MPEG-1 parsed field types
`default_nettype none

package mpeg_fields_pkg;

   typedef enum logic [2:0] {
      HUNT,
      PACK,
      SYSHDR_LEN,
      SYSHDR_SKIP,
      PES,
      DONE
   } ctrl_mode_e;

   typedef struct packed {
      logic [32:0] scr;
      logic [21:0] mux_rate;
   } pack_info_t;

   typedef struct packed {
      logic [7:0]  stream_id;
      logic [15:0] packet_length;
      logic        has_std;
      logic        std_scale;
      logic [12:0] std_size;
      logic        has_pts;
      logic        has_dts;
      logic [32:0] pts;
      logic [32:0] dts;
   } pes_info_t;

   typedef struct packed {
      logic [7:0] stream_id;
      logic [7:0] data;
   } payload_t;

   // '01' scale size[12:8]
   typedef struct packed {
      logic [1:0] prefix;
      logic       scale;
      logic [4:0] size_hi;
   } std_lead_t;

   // '001x' ts[32:30] marker
   typedef struct packed {
      logic [3:0] prefix;
      logic [2:0] ts_hi;
      logic       marker;
   } ts_lead_t;

   typedef union packed {
      std_lead_t std_view;
      ts_lead_t  ts_view;
   } pes_lead_u;

endpackage

`default_nettype wire

// ==== verilog/bit_deserializer.sv ====
// Serial to byte deserializer
`timescale 1ns/1ps
`default_nettype none

module bit_deserializer (
   input  logic       clk,
   input  logic       rst,
   input  logic       serial_in,
   output logic [7:0] byte_data,
   output logic       byte_valid
);

   logic [2:0] bit_cnt;
   logic [7:0] shift_reg;

   assign byte_data = shift_reg;  // whole byte while byte_valid is high

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         bit_cnt    <= 3'd0;
         byte_valid <= 1'b0;
      end
      else
      begin
         bit_cnt    <= bit_cnt + 3'd1;
         byte_valid <= (bit_cnt == 3'd7);  // eighth bit shifted this edge
      end
   end

   always_ff @(posedge clk)
   begin
      shift_reg <= {shift_reg[6:0], serial_in};  // msb first
   end

endmodule

`default_nettype wire

// ==== verilog/start_code_scanner.sv ====
// Start code prefix scanner
`timescale 1ns/1ps
`default_nettype none

module start_code_scanner
   import mpeg_codes_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic [7:0] byte_data,
   input  logic       byte_valid,
   input  logic       hunt,
   output logic [7:0] code,
   output logic       code_valid
);

   typedef enum logic [1:0] {
      SCAN_IDLE,
      SCAN_ZERO1,
      SCAN_ZERO2,  // two or more zero bytes seen
      SCAN_CODE
   } scan_state_e;

   scan_state_e state;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state      <= SCAN_IDLE;
         code_valid <= 1'b0;
      end
      else
      begin
         code_valid <= 1'b0;
         if (!hunt)
            state <= SCAN_IDLE;  // restart on every hunt
         else if (byte_valid)
         begin
            case (state)
               SCAN_IDLE:
                  if (byte_data == PREFIX_ZERO)
                     state <= SCAN_ZERO1;
               SCAN_ZERO1:
                  state <= (byte_data == PREFIX_ZERO) ? SCAN_ZERO2 : SCAN_IDLE;
               SCAN_ZERO2:
                  if (byte_data == PREFIX_LAST)
                     state <= SCAN_CODE;
                  else if (byte_data != PREFIX_ZERO)
                     state <= SCAN_IDLE;  // extra zeros keep the match
               SCAN_CODE:
               begin
                  code_valid <= 1'b1;
                  state      <= SCAN_IDLE;
               end
               default:
                  state <= SCAN_IDLE;
            endcase
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (hunt && byte_valid && state == SCAN_CODE)
         code <= byte_data;
   end

endmodule

`default_nettype wire

// ==== verilog/pack_header_parser.sv ====
// Pack header parser
`timescale 1ns/1ps
`default_nettype none

module pack_header_parser
   import mpeg_fields_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic [7:0] byte_data,
   input  logic       byte_valid,
   input  logic       start,
   output pack_info_t pack_info,
   output logic       pack_valid,
   output logic       done
);

   logic        busy;
   logic [2:0]  byte_cnt;
   logic [63:0] hdr;  // byte 0 in the top bits

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         busy       <= 1'b0;
         byte_cnt   <= 3'd0;
         pack_valid <= 1'b0;
      end
      else
      begin
         pack_valid <= 1'b0;
         if (start)
         begin
            busy     <= 1'b1;
            byte_cnt <= 3'd0;
         end
         else if (busy && byte_valid)
         begin
            byte_cnt <= byte_cnt + 3'd1;
            if (byte_cnt == 3'd7)
            begin
               busy       <= 1'b0;
               pack_valid <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (busy && byte_valid)
         hdr <= {hdr[55:0], byte_data};
   end

   // '0010' prefix and markers dropped
   assign pack_info.scr = {hdr[59:57], hdr[55:48], hdr[47:41], hdr[39:32], hdr[31:25]};
   assign pack_info.mux_rate = {hdr[22:16], hdr[15:8], hdr[7:1]};

   assign done = pack_valid;  // header is the whole section

endmodule

`default_nettype wire

// ==== verilog/pes_header_parser.sv ====
// PES packet parser
`timescale 1ns/1ps
`default_nettype none

module pes_header_parser
   import mpeg_codes_pkg::*;
   import mpeg_fields_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic [7:0] byte_data,
   input  logic       byte_valid,
   input  logic       start,
   input  logic [7:0] stream_id,
   output pes_info_t  pes_info,
   output logic       pes_valid,
   output payload_t   payload,
   output logic       payload_valid,
   output logic       done
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_LEN_HI,
      ST_LEN_LO,
      ST_LEAD,     // stuffing, STD or timestamp lead byte
      ST_STD_LO,
      ST_TS,
      ST_PAYLOAD
   } pes_state_e;

   pes_state_e  state;
   logic [15:0] rem;      // bytes left in the packet
   logic [3:0]  ts_idx;   // timestamp byte after the lead
   pes_lead_u   lead;
   logic [15:0] len_word;
   logic        last_byte;
   logic        is_std;
   logic        is_ts;
   logic        is_none;
   logic        ts_end;
   logic        hdr_fin;

   assign lead      = byte_data;  // same byte, two views
   assign len_word  = {pes_info.packet_length[15:8], byte_data};
   assign last_byte = (rem == 16'd1);
   assign is_none   = (byte_data == TS_NONE_BYTE);
   assign is_std    = (lead.std_view.prefix == STD_PREFIX);
   assign is_ts     = (lead.ts_view.prefix == TS_PTS_PREFIX) ||
                      (lead.ts_view.prefix == TS_PTS_DTS_PREFIX);
   assign ts_end    = (ts_idx == (pes_info.has_dts ? 4'd9 : 4'd4));

   // header ends on this byte
   always_comb
   begin
      case (state)
         ST_LEAD:   hdr_fin = last_byte || is_none;
         ST_STD_LO: hdr_fin = last_byte;
         ST_TS:     hdr_fin = last_byte || ts_end;
         default:   hdr_fin = 1'b0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state         <= ST_IDLE;
         pes_valid     <= 1'b0;
         payload_valid <= 1'b0;
         done          <= 1'b0;
      end
      else
      begin
         pes_valid     <= 1'b0;
         payload_valid <= 1'b0;
         done          <= 1'b0;
         if (start)
            state <= ST_LEN_HI;
         else if (byte_valid)
         begin
            case (state)
               ST_LEN_HI:
                  state <= ST_LEN_LO;
               ST_LEN_LO:
               begin
                  rem <= len_word;
                  if (len_word == 16'd0)
                  begin
                     pes_valid <= 1'b1;  // empty packet
                     done      <= 1'b1;
                     state     <= ST_IDLE;
                  end
                  else if (pes_info.stream_id == PRIVATE_STREAM_2)
                  begin
                     pes_valid <= 1'b1;
                     state     <= ST_PAYLOAD;
                  end
                  else
                     state <= ST_LEAD;
               end
               ST_LEAD:
               begin
                  rem <= rem - 16'd1;
                  if (is_std)
                     state <= ST_STD_LO;
                  else if (is_ts)
                  begin
                     ts_idx <= 4'd1;
                     state  <= ST_TS;
                  end
               end
               ST_STD_LO:
               begin
                  rem   <= rem - 16'd1;
                  state <= ST_LEAD;  // second lead byte follows
               end
               ST_TS:
               begin
                  rem    <= rem - 16'd1;
                  ts_idx <= ts_idx + 4'd1;
               end
               ST_PAYLOAD:
               begin
                  rem           <= rem - 16'd1;
                  payload_valid <= 1'b1;
                  if (last_byte)
                  begin
                     done  <= 1'b1;
                     state <= ST_IDLE;
                  end
               end
               default:
                  state <= ST_IDLE;
            endcase
            if (hdr_fin)
            begin
               pes_valid <= 1'b1;
               done      <= last_byte;
               state     <= last_byte ? ST_IDLE : ST_PAYLOAD;
            end
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (start)
      begin
         pes_info           <= '0;
         pes_info.stream_id <= stream_id;
      end
      else if (byte_valid)
      begin
         case (state)
            ST_LEN_HI: pes_info.packet_length[15:8] <= byte_data;
            ST_LEN_LO: pes_info.packet_length[7:0]  <= byte_data;
            ST_LEAD:
               if (is_std)
               begin
                  pes_info.has_std         <= 1'b1;
                  pes_info.std_scale       <= lead.std_view.scale;
                  pes_info.std_size[12:8]  <= lead.std_view.size_hi;
               end
               else if (is_ts)
               begin
                  pes_info.has_pts     <= 1'b1;
                  pes_info.has_dts     <= (lead.ts_view.prefix == TS_PTS_DTS_PREFIX);
                  pes_info.pts[32:30]  <= lead.ts_view.ts_hi;
               end
            ST_STD_LO: pes_info.std_size[7:0] <= byte_data;
            ST_TS:
               case (ts_idx)  // markers in bit 0 dropped
                  4'd1: pes_info.pts[29:22] <= byte_data;
                  4'd2: pes_info.pts[21:15] <= byte_data[7:1];
                  4'd3: pes_info.pts[14:7]  <= byte_data;
                  4'd4: pes_info.pts[6:0]   <= byte_data[7:1];
                  4'd5: pes_info.dts[32:30] <= lead.ts_view.ts_hi;
                  4'd6: pes_info.dts[29:22] <= byte_data;
                  4'd7: pes_info.dts[21:15] <= byte_data[7:1];
                  4'd8: pes_info.dts[14:7]  <= byte_data;
                  default: pes_info.dts[6:0] <= byte_data[7:1];
               endcase
            ST_PAYLOAD:
            begin
               payload.stream_id <= pes_info.stream_id;
               payload.data      <= byte_data;
            end
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== verilog/stream_ctrl.sv ====
// System stream control FSM
`timescale 1ns/1ps
`default_nettype none

module stream_ctrl
   import mpeg_codes_pkg::*;
   import mpeg_fields_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic [7:0] code,
   input  logic       code_valid,
   input  logic [7:0] byte_data,
   input  logic       byte_valid,
   input  logic       pack_done,
   input  logic       pes_done,
   output logic       hunt,
   output logic       pack_start,
   output logic       pes_start,
   output logic [7:0] stream_id,
   output logic       stream_end
);

   ctrl_mode_e  mode;
   logic [15:0] skip_cnt;     // system header length, then bytes left
   logic        len_hi_seen;
   logic [15:0] len_word;

   assign hunt     = (mode == HUNT);
   assign len_word = {skip_cnt[15:8], byte_data};

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         mode        <= HUNT;
         pack_start  <= 1'b0;
         pes_start   <= 1'b0;
         stream_end  <= 1'b0;
         len_hi_seen <= 1'b0;
      end
      else
      begin
         pack_start <= 1'b0;
         pes_start  <= 1'b0;
         case (mode)
            HUNT:
               if (code_valid)
               begin
                  if (code == PACK_START_CODE)
                  begin
                     mode       <= PACK;
                     pack_start <= 1'b1;
                  end
                  else if (code == SYS_HEADER_CODE)
                  begin
                     mode        <= SYSHDR_LEN;
                     len_hi_seen <= 1'b0;
                  end
                  else if (code == END_CODE)
                  begin
                     mode       <= DONE;
                     stream_end <= 1'b1;  // sticky
                  end
                  else if (code >= FIRST_PES_ID)
                  begin
                     mode      <= PES;
                     pes_start <= 1'b1;
                  end
               end
            PACK:
               if (pack_done)
                  mode <= HUNT;
            PES:
               if (pes_done)
                  mode <= HUNT;
            SYSHDR_LEN:
               if (byte_valid)
               begin
                  if (!len_hi_seen)
                     len_hi_seen <= 1'b1;
                  else if (len_word == 16'd0)
                     mode <= HUNT;
                  else
                     mode <= SYSHDR_SKIP;
               end
            SYSHDR_SKIP:
               if (byte_valid && skip_cnt == 16'd1)
                  mode <= HUNT;
            default: ;  // DONE holds until reset
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (mode == HUNT && code_valid)
         stream_id <= code;
      if (byte_valid && mode == SYSHDR_LEN)
         skip_cnt <= len_hi_seen ? len_word : {byte_data, skip_cnt[7:0]};
      else if (byte_valid && mode == SYSHDR_SKIP)
         skip_cnt <= skip_cnt - 16'd1;
   end

endmodule

`default_nettype wire

// ==== verilog/mpeg_sys_decoder.sv ====
// MPEG-1 system stream decoder
`timescale 1ns/1ps
`default_nettype none

module mpeg_sys_decoder
   import mpeg_fields_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic       serial_in,
   output pack_info_t pack_info,
   output logic       pack_valid,
   output pes_info_t  pes_info,
   output logic       pes_valid,
   output payload_t   payload,
   output logic       payload_valid,
   output logic       stream_end
);

   logic [7:0] byte_data;
   logic       byte_valid;
   logic       hunt;
   logic [7:0] code;
   logic       code_valid;
   logic       pack_start;
   logic       pes_start;
   logic [7:0] stream_id;
   logic       pack_done;
   logic       pes_done;

   bit_deserializer u_deser (
      .clk(clk), .rst(rst), .serial_in(serial_in),
      .byte_data(byte_data), .byte_valid(byte_valid)
   );

   start_code_scanner u_scan (
      .clk(clk), .rst(rst), .byte_data(byte_data), .byte_valid(byte_valid),
      .hunt(hunt), .code(code), .code_valid(code_valid)
   );

   stream_ctrl u_ctrl (
      .clk(clk), .rst(rst), .code(code), .code_valid(code_valid),
      .byte_data(byte_data), .byte_valid(byte_valid),
      .pack_done(pack_done), .pes_done(pes_done), .hunt(hunt),
      .pack_start(pack_start), .pes_start(pes_start),
      .stream_id(stream_id), .stream_end(stream_end)
   );

   pack_header_parser u_pack (
      .clk(clk), .rst(rst), .byte_data(byte_data), .byte_valid(byte_valid),
      .start(pack_start), .pack_info(pack_info), .pack_valid(pack_valid),
      .done(pack_done)
   );

   pes_header_parser u_pes (
      .clk(clk), .rst(rst), .byte_data(byte_data), .byte_valid(byte_valid),
      .start(pes_start), .stream_id(stream_id), .pes_info(pes_info),
      .pes_valid(pes_valid), .payload(payload), .payload_valid(payload_valid),
      .done(pes_done)
   );

endmodule

`default_nettype wire

// ==== bench/mpeg_sys_decoder_assert.sv ====
// Decoder output assertions
`timescale 1ns/1ps
`default_nettype none

module mpeg_sys_decoder_assert (
   input logic clk,
   input logic rst,
   input logic pack_valid,
   input logic pes_valid,
   input logic payload_valid,
   input logic stream_end
);

   int unsigned fail_cnt = 0;

   quiet_in_reset: assert property (@(posedge clk)
      $past(rst) |-> !(pack_valid || pes_valid || payload_valid || stream_end))
   else
   begin
      fail_cnt++;
      $error("valid output or stream_end while in reset");
   end

   // one byte per 8 clocks at most
   payload_spacing: assert property (@(posedge clk) disable iff (rst)
      payload_valid |=> !payload_valid [*7])
   else
   begin
      fail_cnt++;
      $error("payload_valid strobes closer than 8 cycles");
   end

   end_is_sticky: assert property (@(posedge clk) disable iff (rst)
      $past(stream_end) |-> stream_end)
   else
   begin
      fail_cnt++;
      $error("stream_end fell outside reset");
   end

endmodule

bind mpeg_sys_decoder mpeg_sys_decoder_assert assert_i (
   .clk(clk), .rst(rst), .pack_valid(pack_valid), .pes_valid(pes_valid),
   .payload_valid(payload_valid), .stream_end(stream_end)
);

`default_nettype wire

// ==== bench/mpeg_sys_decoder_tb.sv ====
// MPEG-1 system decoder testbench
`timescale 1ns/1ps
`default_nettype none

module mpeg_sys_decoder_tb
   import mpeg_codes_pkg::*;
   import mpeg_fields_pkg::*;
();

   logic       clk;
   logic       rst;
   logic       serial_in;
   pack_info_t pack_info;
   logic       pack_valid;
   pes_info_t  pes_info;
   logic       pes_valid;
   payload_t   payload;
   logic       payload_valid;
   logic       stream_end;

   logic [7:0] stream_q[$];  // bytes in line order
   pack_info_t pack_q[$];
   pes_info_t  pes_q[$];
   payload_t   pay_q[$];
   int         seed;
   int         errors;
   int         wd_ns;
   bit         gen_done;

   mpeg_sys_decoder dut_i (
      .clk(clk), .rst(rst), .serial_in(serial_in),
      .pack_info(pack_info), .pack_valid(pack_valid),
      .pes_info(pes_info), .pes_valid(pes_valid),
      .payload(payload), .payload_valid(payload_valid),
      .stream_end(stream_end)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic abort_run();
      errors++;
      $display("Some tests failed");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_value(string name, logic [127:0] exp, logic [127:0] got);
      if (got !== exp)
      begin
         $display("FAIL %s exp=%0h got=%0h", name, exp, got);
         abort_run();
      end
   endtask

   function automatic logic [7:0] rand_byte();
      return 8'($random(seed));
   endfunction

   function automatic int rand_range(int lo, int hi);
      return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
   endfunction

   function automatic logic [63:0] rand_bits();
      return {$random(seed), $random(seed)};
   endfunction

   // expected records, built from the syntax rules
   function automatic pack_info_t pack_expect(logic [32:0] scr, logic [21:0] mux_rate);
      pack_info_t r;
      r.scr      = scr;
      r.mux_rate = mux_rate;
      return r;
   endfunction

   function automatic int pes_length(logic [7:0] id, int n_stuff, bit has_std,
                                     int ts_form, int n_pay);
      int hdr;
      if (id == PRIVATE_STREAM_2)
         return n_pay;  // no header extension
      hdr = n_stuff + (has_std ? 2 : 0);
      hdr = hdr + ((ts_form == 0) ? 1 : (ts_form == 1) ? 5 : 10);
      return hdr + n_pay;
   endfunction

   function automatic pes_info_t pes_expect(logic [7:0] id, int len, bit has_std, bit scale,
                                            logic [12:0] size, int ts_form,
                                            logic [32:0] pts, logic [32:0] dts);
      pes_info_t r;
      r               = '0;
      r.stream_id     = id;
      r.packet_length = len[15:0];
      if (id != PRIVATE_STREAM_2)
      begin
         r.has_std = has_std;
         if (has_std)
         begin
            r.std_scale = scale;
            r.std_size  = size;
         end
         r.has_pts = (ts_form != 0);
         r.has_dts = (ts_form == 2);
         if (ts_form != 0)
            r.pts = pts;
         if (ts_form == 2)
            r.dts = dts;
      end
      return r;
   endfunction

   // 4-bit prefix, timestamp split 3/15/15 with marker bits
   function automatic logic [39:0] ts_word(logic [3:0] prefix, logic [32:0] ts);
      return {prefix, ts[32:30], 1'b1, ts[29:15], 1'b1, ts[14:0], 1'b1};
   endfunction

   task automatic push_bytes(logic [63:0] w, int n);
      int i;
      for (i = n - 1; i >= 0; i--)
         stream_q.push_back(w[i*8 +: 8]);
   endtask

   task automatic add_prefix(logic [7:0] code);
      push_bytes({32'h0, 24'h000001, code}, 4);
   endtask

   task automatic add_pack();
      logic [63:0] r;
      logic [32:0] scr;
      logic [21:0] mux;
      r   = rand_bits();
      scr = r[32:0];
      mux = r[63:42];
      add_prefix(PACK_START_CODE);
      push_bytes({4'b0010, scr[32:30], 1'b1, scr[29:15], 1'b1, scr[14:0], 1'b1,
                  1'b1, mux, 1'b1}, 8);
      pack_q.push_back(pack_expect(scr, mux));
   endtask

   task automatic add_sys_header();
      int len;
      int i;
      len = rand_range(0, 15);
      add_prefix(SYS_HEADER_CODE);
      push_bytes(len, 2);
      for (i = 0; i < len; i++)
         stream_q.push_back(rand_byte());  // body is skipped whole
   endtask

   task automatic add_pes(logic [7:0] id, int n_stuff, bit has_std, int ts_form, int n_pay);
      logic [63:0] r;
      logic [32:0] pts;
      logic [32:0] dts;
      logic [12:0] size;
      logic [7:0]  d;
      bit          scale;
      int          len;
      int          i;
      r     = rand_bits();
      pts   = r[32:0];
      dts   = r[63:31];
      size  = r[12:0] ^ r[60:48];
      scale = r[40];
      len   = pes_length(id, n_stuff, has_std, ts_form, n_pay);
      add_prefix(id);
      push_bytes(len, 2);
      if (id != PRIVATE_STREAM_2)
      begin
         for (i = 0; i < n_stuff; i++)
            stream_q.push_back(STUFFING_BYTE);
         if (has_std)
            push_bytes({STD_PREFIX, scale, size}, 2);
         if (ts_form == 0)
            stream_q.push_back(TS_NONE_BYTE);
         else if (ts_form == 1)
            push_bytes(ts_word(TS_PTS_PREFIX, pts), 5);
         else
         begin
            push_bytes(ts_word(TS_PTS_DTS_PREFIX, pts), 5);
            push_bytes(ts_word(4'b0001, dts), 5);
         end
      end
      pes_q.push_back(pes_expect(id, len, has_std, scale, size, ts_form, pts, dts));
      for (i = 0; i < n_pay; i++)
      begin
         d = rand_byte();
         stream_q.push_back(d);
         pay_q.push_back({id, d});
      end
   endtask

   task automatic build_stream();
      int i;
      int n;
      n = rand_range(4, 10);
      for (i = 0; i < n; i++)
         stream_q.push_back(rand_byte() | 8'h80);  // never part of a prefix
      add_pack();
      add_pes(8'hC0, rand_range(1, 3), 1'b0, 1, rand_range(1, 6));
      add_pes(8'hE0, rand_range(0, 3), 1'b1, 2, rand_range(1, 6));
      add_pes(PRIVATE_STREAM_2, 0, 1'b0, 0, rand_range(1, 8));
      add_sys_header();
      stream_q.push_back(8'h00);  // third zero ahead of the prefix
      add_pack();
      for (i = 0; i < 6; i++)
         add_pes(8'hC0 + rand_range(0, 47), rand_range(0, 3), rand_range(0, 1),
                 rand_range(0, 2), rand_range(0, 6));
      add_prefix(END_CODE);
   endtask

   task automatic send_byte(logic [7:0] b);
      int i;
      for (i = 7; i >= 0; i--)
      begin
         serial_in = b[i];  // msb first
         @(posedge clk);
         #1;
      end
   endtask

   task automatic compare_pack();
      pack_info_t e;
      if (pack_q.size() == 0)
      begin
         $display("pack header output with no pack header left in the stream");
         abort_run();
      end
      else
      begin
         e = pack_q.pop_front();
         check_value("pack_info.scr", e.scr, pack_info.scr);
         check_value("pack_info.mux_rate", e.mux_rate, pack_info.mux_rate);
      end
   endtask

   task automatic compare_pes();
      pes_info_t e;
      if (pes_q.size() == 0)
      begin
         $display("PES header output with no PES packet left in the stream");
         abort_run();
      end
      else
      begin
         e = pes_q.pop_front();
         check_value("pes_info.stream_id", e.stream_id, pes_info.stream_id);
         check_value("pes_info.packet_length", e.packet_length, pes_info.packet_length);
         check_value("pes_info.has_std", e.has_std, pes_info.has_std);
         check_value("pes_info.std_scale", e.std_scale, pes_info.std_scale);
         check_value("pes_info.std_size", e.std_size, pes_info.std_size);
         check_value("pes_info.has_pts", e.has_pts, pes_info.has_pts);
         check_value("pes_info.has_dts", e.has_dts, pes_info.has_dts);
         check_value("pes_info.pts", e.pts, pes_info.pts);
         check_value("pes_info.dts", e.dts, pes_info.dts);
      end
   endtask

   task automatic compare_payload();
      payload_t e;
      if (pay_q.size() == 0)
      begin
         $display("payload byte output with no payload left in the stream");
         abort_run();
      end
      else
      begin
         e = pay_q.pop_front();
         check_value("payload.stream_id", e.stream_id, payload.stream_id);
         check_value("payload.data", e.data, payload.data);
      end
   endtask

   // outputs settle after the rising edge
   always @(negedge clk)
   begin
      check_value("assertion failures", 0, dut_i.assert_i.fail_cnt);
      if (stream_end === 1'b1 &&
          (pack_valid === 1'b1 || pes_valid === 1'b1 || payload_valid === 1'b1))
      begin
         $display("decoder produced output after the end code");
         abort_run();
      end
      else
      begin
         if (pack_valid === 1'b1)
            compare_pack();
         if (pes_valid === 1'b1)
            compare_pes();
         if (payload_valid === 1'b1)
            compare_payload();
      end
   end

   initial
   begin
      wait (gen_done);
      wd_ns = (stream_q.size() * 8 + 200) * 4;
      #(wd_ns);
      $display("decoder stalled, end code not seen within %0d ns", wd_ns);
      abort_run();
   end

   initial
   begin
      int i;
      rst       = 1'b1;
      serial_in = 1'b0;
      seed      = 54684;
      errors    = 0;
      build_stream();
      gen_done = 1'b1;
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;
      for (i = 0; i < stream_q.size(); i++)
         send_byte(stream_q[i]);
      serial_in = 1'b0;
      wait (stream_end === 1'b1);
      repeat (40) @(posedge clk);  // quiet period after the end code
      @(negedge clk);
      check_value("pending pack records", 0, pack_q.size());
      check_value("pending pes records", 0, pes_q.size());
      check_value("pending payload bytes", 0, pay_q.size());
      if (errors == 0)
      begin
         $display("All tests passed");
         $finish;
      end
      else
         abort_run();
   end

endmodule

`default_nettype wire

// ==== flist.f ====
verilog/mpeg_codes_pkg.sv
verilog/mpeg_fields_pkg.sv
verilog/bit_deserializer.sv
verilog/start_code_scanner.sv
verilog/pack_header_parser.sv
verilog/pes_header_parser.sv
verilog/stream_ctrl.sv
verilog/mpeg_sys_decoder.sv
bench/mpeg_sys_decoder_assert.sv
bench/mpeg_sys_decoder_tb.sv

// ==== Bender.yml ====
package:
  name: mpeg_sys_decoder

sources:
  - files:
      - verilog/mpeg_codes_pkg.sv
      - verilog/mpeg_fields_pkg.sv
      - verilog/bit_deserializer.sv
      - verilog/start_code_scanner.sv
      - verilog/pack_header_parser.sv
      - verilog/pes_header_parser.sv
      - verilog/stream_ctrl.sv
      - verilog/mpeg_sys_decoder.sv
  - target: simulation
    files:
      - bench/mpeg_sys_decoder_assert.sv
      - bench/mpeg_sys_decoder_tb.sv
